/* list.f */
logic/mips_pkg.sv
logic/regfile.sv
logic/ifetch.sv
logic/lsu.sv
logic/sram_arbiter.sv
logic/exec_unit.sv
logic/mips_core.sv
bench/sram_model.sv
bench/tb_mips_core.sv

/* Bender.yml */
package:
  name: mips_core

sources:
  - logic/mips_pkg.sv
  - logic/regfile.sv
  - logic/ifetch.sv
  - logic/lsu.sv
  - logic/sram_arbiter.sv
  - logic/exec_unit.sv
  - logic/mips_core.sv
  - target: test
    files:
      - bench/sram_model.sv
      - bench/tb_mips_core.sv

/* bench/program.hex */
// One 32-bit word per line in hex; @20 moves to word 32 (byte 0x80) for the data.
3c018000  // 00 lui   r1, 0x8000
34020080  // 04 ori   r2, r0, 0x0080
2403fffb  // 08 addiu r3, r0, -5
0062202a  // 0c slt   r4, r3, r2
8c450000  // 10 lw    r5, 0(r2)
00a33023  // 14 subu  r6, r5, r3
ac460004  // 18 sw    r6, 4(r2)
8c470004  // 1c lw    r7, 4(r2)
00e40024  // 20 and   r0, r7, r4
00074021  // 24 addu  r8, r0, r7
10800001  // 28 beq   r4, r0, 1
14e60001  // 2c bne   r7, r6, 1
11060001  // 30 beq   r8, r6, 1
34090001  // 34 ori   r9, r0, 1
14800001  // 38 bne   r4, r0, 1
34090002  // 3c ori   r9, r0, 2
08000010  // 40 j     0x40
@20
12345678  // 80 load source
deadbeef  // 84 overwritten by the store

/* bench/tb_mips_core.sv */
`timescale 1ns/1ns

module tb_mips_core;

    import mips_pkg::*;

    localparam logic [31:0] RESET_PC = 32'h0000_0000;
    // Fifteen instructions reach the final jump, which then spins on itself.
    localparam int RETIRES    = 18;
    localparam int MAX_CYCLES = 40 * RETIRES;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        rst_q = 1'b0;
    logic        fetched = 1'b0;
    bus_req_t    bus_req;
    bus_rsp_t    bus_rsp;
    dbg_wb_t     dbg;
    logic [31:0] bus_errors;
    int          errors = 0;
    int          cycles = 0;
    int          retired = 0;

    logic [31:0] g_mem [64];
    logic [31:0] g_regs [32];
    logic [31:0] g_pc;
    logic [31:0] exp_pc;
    logic [3:0]  exp_wen;
    logic [4:0]  exp_wnum;
    logic [31:0] exp_wdata;

    mips_core #(.RESET_PC(RESET_PC)) u_mips_core (.clk(clk), .rst(rst),
        .bus_req_o(bus_req), .bus_rsp_i(bus_rsp), .dbg_o(dbg));

    sram_model u_sram_model (.clk(clk), .rst(rst), .req_i(bus_req), .rsp_o(bus_rsp),
        .err_count_o(bus_errors));

    always #10 clk = ~clk;

    task automatic report_mismatch(string name, logic [31:0] expected, logic [31:0] actual);
        $display("error %s: expected %h, actual %h", name, expected, actual);
        errors = errors + 1;
    endtask

    // Reference interpreter, one instruction per call, read straight off the encoding.
    task automatic step_reference();
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] ea;
        logic [31:0] next;
        logic [31:0] res;
        logic [4:0]  rd;
        logic        wr;
        ins  = g_mem[g_pc[7:2]];
        a    = g_regs[ins[25:21]];
        b    = g_regs[ins[20:16]];
        simm = {{16{ins[15]}}, ins[15:0]};
        ea   = a + simm;
        next = g_pc + 32'd4;
        res  = 32'd0;
        rd   = ins[20:16];
        wr   = 1'b1;
        case (ins[31:26])
            6'h00: begin
                rd = ins[15:11];
                case (ins[5:0])
                    6'h21: res = a + b;
                    6'h23: res = a - b;
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h2a: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wr = 1'b0;
                endcase
            end
            6'h09: res = a + simm;
            6'h0d: res = a | {16'h0000, ins[15:0]};
            6'h0f: res = {ins[15:0], 16'h0000};
            6'h23: res = g_mem[ea[7:2]];
            6'h2b: begin
                wr = 1'b0;
                g_mem[ea[7:2]] = b;
            end
            6'h04: begin
                wr = 1'b0;
                if (a == b) begin
                    next = next + (simm << 2);
                end
            end
            6'h05: begin
                wr = 1'b0;
                if (a != b) begin
                    next = next + (simm << 2);
                end
            end
            6'h02: begin
                wr   = 1'b0;
                next = {next[31:28], ins[25:0], 2'b00};
            end
            default: wr = 1'b0;
        endcase
        exp_pc    = g_pc;
        exp_wen   = (wr && rd != 5'd0) ? 4'hf : 4'h0;
        exp_wnum  = rd;
        exp_wdata = res;
        if (exp_wen != 4'h0) begin
            g_regs[rd] = res;
        end
        g_pc = next;
    endtask

    always @(posedge clk) begin
        rst_q <= rst;
        if (!rst) begin
            cycles <= cycles + 1;
        end
        if (!rst && bus_req.req && bus_rsp.addr_ok) begin
            fetched <= 1'b1;
        end
        if (!rst && dbg.valid) begin
            retired = retired + 1;
            step_reference();
        end
    end

    a_reset_req: assert property (@(posedge clk) rst_q |-> !bus_req.req)
        else report_mismatch("reset_req", 32'd0, {31'd0, $sampled(bus_req.req)});
    a_first_fetch: assert property (@(posedge clk) disable iff (rst)
        bus_req.req && !fetched |-> bus_req.addr == RESET_PC)
        else report_mismatch("first_fetch", RESET_PC, $sampled(bus_req.addr));
    a_debug_pc: assert property (@(posedge clk) disable iff (rst)
        dbg.valid |-> dbg.pc == exp_pc)
        else report_mismatch("debug_pc", $sampled(exp_pc), $sampled(dbg.pc));
    a_debug_wen: assert property (@(posedge clk) disable iff (rst)
        dbg.valid |-> dbg.rf_wen == exp_wen)
        else report_mismatch("debug_wen", $sampled(exp_wen), $sampled(dbg.rf_wen));
    a_debug_wnum: assert property (@(posedge clk) disable iff (rst)
        dbg.valid && exp_wen != 4'h0 |-> dbg.rf_wnum == exp_wnum)
        else report_mismatch("debug_wnum", $sampled(exp_wnum), $sampled(dbg.rf_wnum));
    a_debug_wdata: assert property (@(posedge clk) disable iff (rst)
        dbg.valid && exp_wen != 4'h0 |-> dbg.rf_wdata == exp_wdata)
        else report_mismatch("debug_wdata", $sampled(exp_wdata), $sampled(dbg.rf_wdata));

    initial begin
        $readmemh("bench/program.hex", g_mem);
        for (int i = 0; i < 32; i++) begin
            g_regs[i] = 32'd0;
        end
        g_pc = RESET_PC;
        step_reference();
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;
        while (retired < RETIRES && cycles < MAX_CYCLES) begin
            @(negedge clk);
        end
        if (retired < RETIRES) begin
            $display("timeout: %0d of %0d instructions retired in %0d cycles",
                retired, RETIRES, cycles);
            errors = errors + 1;
        end else begin
            for (int i = 0; i < 64; i++) begin
                assert (u_sram_model.mem[i] === g_mem[i])
                    else report_mismatch($sformatf("memory_dump word %0d", i),
                        g_mem[i], u_sram_model.mem[i]);
            end
        end
        $display("retired %0d, errors %0d, bus errors %0d", retired, errors, bus_errors);
        if (errors == 0 && bus_errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* bench/sram_model.sv */
`timescale 1ns/1ns

module sram_model (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::bus_req_t req_i,
    output mips_pkg::bus_rsp_t rsp_o,
    output logic [31:0]        err_count_o
);

    import mips_pkg::*;

    logic [31:0] mem [64];
    bus_rsp_t    rsp_q;
    logic        pending;
    logic [31:0] addr_q;
    logic [1:0]  wait_cnt;
    integer      seed = 5;

    initial begin
        $readmemh("bench/program.hex", mem);
        rsp_o       = '0;
        err_count_o = '0;
    end

    // Each phase of a transfer waits 0 to 3 cycles before it is answered.
    always @(posedge clk) begin
        if (rst) begin
            rsp_q    <= '0;
            pending  <= 1'b0;
            wait_cnt <= 2'($random(seed));
        end else begin
            rsp_q.addr_ok <= 1'b0;
            rsp_q.data_ok <= 1'b0;
            if (rsp_q.data_ok) begin
                pending  <= 1'b0;
                wait_cnt <= 2'($random(seed));
            end else if (pending) begin
                if (wait_cnt == 2'd0) begin
                    rsp_q.data_ok <= 1'b1;
                    rsp_q.rdata   <= mem[addr_q[7:2]];
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end else if (rsp_q.addr_ok && req_i.req) begin
                pending  <= 1'b1;
                addr_q   <= req_i.addr;
                wait_cnt <= 2'($random(seed));
                if (req_i.wr) begin
                    mem[req_i.addr[7:2]] <= req_i.wdata;
                end
            end else if (req_i.req) begin
                if (wait_cnt == 2'd0) begin
                    rsp_q.addr_ok <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 2'd1;
                end
            end
        end
    end

    // The core sees the response a short time after the clock edge.
    always @(posedge clk) begin
        #2;
        rsp_o = rsp_q;
    end

    a_one_outstanding: assert property (@(posedge clk) disable iff (rst)
        pending |-> !req_i.req)
        else begin
            $display("bus error: a second request was raised before data_ok");
            err_count_o = err_count_o + 1;
        end

    a_req_stable: assert property (@(posedge clk) disable iff (rst)
        req_i.req && !rsp_q.addr_ok |=> $stable(req_i))
        else begin
            $display("bus error: the request changed or dropped before addr_ok");
            err_count_o = err_count_o + 1;
        end

endmodule

/* logic/mips_core.sv */
`timescale 1ns/1ns

module mips_core #(
    parameter logic [31:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic               clk,
    input  logic               rst,
    output mips_pkg::bus_req_t bus_req_o,
    input  mips_pkg::bus_rsp_t bus_rsp_i,
    output mips_pkg::dbg_wb_t  dbg_o
);

    import mips_pkg::*;

    bus_req_t    if_req, ls_req;
    bus_rsp_t    if_rsp, ls_rsp;
    inst_u       inst;
    mem_op_t     mem_op;
    logic        inst_valid, fetch_next, mem_start, mem_done, rf_we;
    logic [31:0] pc, next_pc, load_data, rdata1, rdata2, rf_wdata;
    logic [4:0]  raddr1, raddr2, rf_waddr;

    regfile u_regfile (.clk(clk), .rst(rst), .raddr1_i(raddr1), .raddr2_i(raddr2),
        .rdata1_o(rdata1), .rdata2_o(rdata2), .we_i(rf_we), .waddr_i(rf_waddr),
        .wdata_i(rf_wdata));

    ifetch #(.RESET_PC(RESET_PC)) u_ifetch (.clk(clk), .rst(rst),
        .fetch_next_i(fetch_next), .next_pc_i(next_pc),
        .bus_req_o(if_req), .bus_rsp_i(if_rsp),
        .inst_valid_o(inst_valid), .inst_o(inst), .pc_o(pc));

    lsu u_lsu (.clk(clk), .rst(rst), .mem_start_i(mem_start), .mem_op_i(mem_op),
        .bus_req_o(ls_req), .bus_rsp_i(ls_rsp),
        .mem_done_o(mem_done), .load_data_o(load_data));

    // Data accesses take the shared bus ahead of instruction fetch.
    sram_arbiter u_sram_arbiter (.clk(clk), .rst(rst),
        .if_req_i(if_req), .if_rsp_o(if_rsp), .ls_req_i(ls_req), .ls_rsp_o(ls_rsp),
        .bus_req_o(bus_req_o), .bus_rsp_i(bus_rsp_i));

    exec_unit u_exec_unit (.clk(clk), .rst(rst),
        .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(pc),
        .rf_raddr1_o(raddr1), .rf_raddr2_o(raddr2),
        .rf_rdata1_i(rdata1), .rf_rdata2_i(rdata2),
        .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
        .fetch_next_o(fetch_next), .next_pc_o(next_pc),
        .mem_start_o(mem_start), .mem_op_o(mem_op),
        .mem_done_i(mem_done), .load_data_i(load_data), .dbg_o(dbg_o));

endmodule

/* logic/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit (
    input  logic              clk,
    input  logic              rst,
    input  logic              inst_valid_i,
    input  mips_pkg::inst_u   inst_i,
    input  logic [31:0]       pc_i,
    output logic [4:0]        rf_raddr1_o,
    output logic [4:0]        rf_raddr2_o,
    input  logic [31:0]       rf_rdata1_i,
    input  logic [31:0]       rf_rdata2_i,
    output logic              rf_we_o,
    output logic [4:0]        rf_waddr_o,
    output logic [31:0]       rf_wdata_o,
    output logic              fetch_next_o,
    output logic [31:0]       next_pc_o,
    output logic              mem_start_o,
    output mips_pkg::mem_op_t mem_op_o,
    input  logic              mem_done_i,
    input  logic [31:0]       load_data_i,
    output mips_pkg::dbg_wb_t dbg_o
);

    import mips_pkg::*;

    localparam logic [1:0] S_IDLE   = 2'd0;
    localparam logic [1:0] S_MEM    = 2'd1;
    localparam logic [1:0] S_RETIRE = 2'd2;

    logic [1:0]  state_q;
    logic        mem_start_q;
    logic [31:0] simm;
    logic [31:0] pc_plus4;
    logic [31:0] result;
    logic [4:0]  dest;
    logic        writes;
    logic        taken;
    logic        is_mem;
    logic        retire;

    assign simm        = {{16{inst_i.i.imm[15]}}, inst_i.i.imm};
    assign pc_plus4    = pc_i + 32'd4;
    assign rf_raddr1_o = inst_i.r.rs;
    assign rf_raddr2_o = inst_i.r.rt;
    assign is_mem      = inst_i.i.op == OP_LW || inst_i.i.op == OP_SW;

    // Inst and pc hold still until fetch_next, so decode stays valid at retire.
    always_comb begin
        result    = 32'd0;
        dest      = inst_i.i.rt;
        writes    = 1'b1;
        taken     = 1'b0;
        next_pc_o = pc_plus4;
        case (inst_i.r.op)
            OP_SPECIAL: begin
                dest = inst_i.r.rd;
                case (inst_i.r.funct)
                    FN_ADDU: result = rf_rdata1_i + rf_rdata2_i;
                    FN_SUBU: result = rf_rdata1_i - rf_rdata2_i;
                    FN_AND:  result = rf_rdata1_i & rf_rdata2_i;
                    FN_OR:   result = rf_rdata1_i | rf_rdata2_i;
                    FN_SLT:  result = {31'd0, $signed(rf_rdata1_i) < $signed(rf_rdata2_i)};
                    default: writes = 1'b0;
                endcase
            end
            OP_ADDIU: result = rf_rdata1_i + simm;
            OP_ORI:   result = rf_rdata1_i | {16'd0, inst_i.i.imm};
            OP_LUI:   result = {inst_i.i.imm, 16'd0};
            OP_LW:    result = load_data_i;
            OP_BEQ:   taken = rf_rdata1_i == rf_rdata2_i;
            OP_BNE:   taken = rf_rdata1_i != rf_rdata2_i;
            // J stays inside the 256 MB region of the following address
            OP_J:     next_pc_o = {pc_plus4[31:28], inst_i[25:0], 2'b00};
            default:  ;
        endcase
        if (!(inst_i.r.op inside {OP_SPECIAL, OP_ADDIU, OP_ORI, OP_LUI, OP_LW})) begin
            writes = 1'b0;
        end
        if (taken) begin
            next_pc_o = pc_plus4 + {simm[29:0], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q     <= S_IDLE;
            mem_start_q <= 1'b0;
        end else begin
            mem_start_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (inst_valid_i) begin
                        state_q     <= is_mem ? S_MEM : S_RETIRE;
                        mem_start_q <= is_mem;
                    end
                end
                S_MEM: begin
                    if (mem_done_i) begin
                        state_q <= S_RETIRE;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    assign retire       = state_q == S_RETIRE;
    assign fetch_next_o = retire;
    assign rf_we_o      = retire && writes && dest != 5'd0;
    assign rf_waddr_o   = dest;
    assign rf_wdata_o   = result;
    assign mem_start_o  = mem_start_q;
    assign mem_op_o     = '{wr: inst_i.i.op == OP_SW, addr: rf_rdata1_i + simm,
                            wdata: rf_rdata2_i};
    assign dbg_o        = '{valid: retire, pc: pc_i, rf_wen: {4{rf_we_o}},
                            rf_wnum: dest, rf_wdata: result};

endmodule

/* logic/sram_arbiter.sv */
`timescale 1ns/1ns

module sram_arbiter (
    input  logic               clk,
    input  logic               rst,
    input  mips_pkg::bus_req_t if_req_i,
    output mips_pkg::bus_rsp_t if_rsp_o,
    input  mips_pkg::bus_req_t ls_req_i,
    output mips_pkg::bus_rsp_t ls_rsp_o,
    output mips_pkg::bus_req_t bus_req_o,
    input  mips_pkg::bus_rsp_t bus_rsp_i
);

    logic busy_q;
    logic owner_ls_q;
    logic sel_ls;

    // While idle the data side wins; once granted, the owner keeps the bus.
    assign sel_ls = busy_q ? owner_ls_q : ls_req_i.req;

    assign bus_req_o = sel_ls ? ls_req_i : if_req_i;

    always_comb begin
        if_rsp_o = bus_rsp_i;
        ls_rsp_o = bus_rsp_i;
        if_rsp_o.addr_ok = bus_rsp_i.addr_ok & ~sel_ls;
        if_rsp_o.data_ok = bus_rsp_i.data_ok & ~sel_ls;
        ls_rsp_o.addr_ok = bus_rsp_i.addr_ok & sel_ls;
        ls_rsp_o.data_ok = bus_rsp_i.data_ok & sel_ls;
    end

    // The grant is taken in the first request cycle even if addr_ok is
    // still withheld, so the outside bus never sees its request change.
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            owner_ls_q <= 1'b0;
        end else if (!busy_q) begin
            if (if_req_i.req || ls_req_i.req) begin
                busy_q     <= 1'b1;
                owner_ls_q <= ls_req_i.req;
            end
        end else if (bus_rsp_i.data_ok) begin
            busy_q <= 1'b0;
        end
    end

    a_no_idle_data: assert property (@(posedge clk) disable iff (rst)
        bus_rsp_i.data_ok |-> busy_q);

    // The memory only accepts an address that is actually being requested.
    a_addr_ok_req: assert property (@(posedge clk) disable iff (rst)
        bus_rsp_i.addr_ok |-> bus_req_o.req);

endmodule

/* logic/lsu.sv */
`timescale 1ns/1ns

module lsu (
    input  logic               clk,
    input  logic               rst,
    input  logic               mem_start_i,
    input  mips_pkg::mem_op_t  mem_op_i,
    output mips_pkg::bus_req_t bus_req_o,
    input  mips_pkg::bus_rsp_t bus_rsp_i,
    output logic               mem_done_o,
    output logic [31:0]        load_data_o
);

    import mips_pkg::*;

    mem_op_t     op_q;
    logic        req_q;
    logic        wait_q;
    logic        done_q;
    logic [31:0] load_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q  <= 1'b0;
            wait_q <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (mem_start_i) begin
                req_q <= 1'b1;
            end else if (req_q && bus_rsp_i.addr_ok) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end else if (wait_q && bus_rsp_i.data_ok) begin
                wait_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    // Load data stays put until the next load so the retire step can use it.
    always_ff @(posedge clk) begin
        if (mem_start_i) begin
            op_q <= mem_op_i;
        end
        if (wait_q && bus_rsp_i.data_ok && !op_q.wr) begin
            load_q <= bus_rsp_i.rdata;
        end
    end

    assign bus_req_o   = '{req: req_q, wr: op_q.wr, addr: op_q.addr, wdata: op_q.wdata};
    assign mem_done_o  = done_q;
    assign load_data_o = load_q;

    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        mem_start_i |-> !req_q && !wait_q && !done_q);

endmodule

/* logic/ifetch.sv */
`timescale 1ns/1ns

module ifetch #(
    parameter logic [31:0] RESET_PC = 32'hbfc0_0000
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_next_i,
    input  logic [31:0]        next_pc_i,
    output mips_pkg::bus_req_t bus_req_o,
    input  mips_pkg::bus_rsp_t bus_rsp_i,
    output logic               inst_valid_o,
    output mips_pkg::inst_u    inst_o,
    output logic [31:0]        pc_o
);

    logic        boot_q;
    logic        req_q;
    logic        wait_q;
    logic        valid_q;
    logic [31:0] pc_q;
    logic [31:0] inst_q;

    // The first fetch starts by itself once reset is gone.
    always_ff @(posedge clk) begin
        if (rst) begin
            boot_q  <= 1'b1;
            req_q   <= 1'b0;
            wait_q  <= 1'b0;
            valid_q <= 1'b0;
            pc_q    <= RESET_PC;
        end else begin
            valid_q <= 1'b0;
            if (boot_q || fetch_next_i) begin
                boot_q <= 1'b0;
                req_q  <= 1'b1;
            end else if (req_q && bus_rsp_i.addr_ok) begin
                req_q  <= 1'b0;
                wait_q <= 1'b1;
            end else if (wait_q && bus_rsp_i.data_ok) begin
                wait_q  <= 1'b0;
                valid_q <= 1'b1;
            end
            if (fetch_next_i) begin
                pc_q <= next_pc_i;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wait_q && bus_rsp_i.data_ok) begin
            inst_q <= bus_rsp_i.rdata;
        end
    end

    assign bus_req_o    = '{req: req_q, wr: 1'b0, addr: pc_q, wdata: 32'd0};
    assign inst_valid_o = valid_q;
    assign inst_o       = inst_q;
    assign pc_o         = pc_q;

    // Branch and jump targets from the exec unit must stay word aligned.
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        req_q |-> pc_q[1:0] == 2'b00);
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        req_q && !bus_rsp_i.addr_ok |=> req_q && $stable(pc_q));

endmodule

/* logic/regfile.sv */
`timescale 1ns/1ns

module regfile (
    input  logic        clk,
    input  logic        rst,
    input  logic [4:0]  raddr1_i,
    input  logic [4:0]  raddr2_i,
    output logic [31:0] rdata1_o,
    output logic [31:0] rdata2_o,
    input  logic        we_i,
    input  logic [4:0]  waddr_i,
    input  logic [31:0] wdata_i
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (we_i && waddr_i != 5'd0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Entry 0 is never written, so reads of r0 return zero here.
    assign rdata1_o = (raddr1_i == 5'd0) ? 32'd0 : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == 5'd0) ? 32'd0 : regs[raddr2_i];

    // The exec unit drops the write enable for r0 before it gets here.
    a_no_r0_write: assert property (@(posedge clk) disable iff (rst)
        !(we_i && waddr_i == 5'd0));

endmodule

/* logic/mips_pkg.sv */
package mips_pkg;

    // Primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'b000000,
        OP_J       = 6'b000010,
        OP_BEQ     = 6'b000100,
        OP_BNE     = 6'b000101,
        OP_ADDIU   = 6'b001001,
        OP_ORI     = 6'b001101,
        OP_LUI     = 6'b001111,
        OP_LW      = 6'b100011,
        OP_SW      = 6'b101011
    } op_e;

    // Function codes under OP_SPECIAL.
    typedef enum logic [5:0] {
        FN_ADDU = 6'b100001,
        FN_SUBU = 6'b100011,
        FN_AND  = 6'b100100,
        FN_OR   = 6'b100101,
        FN_SLT  = 6'b101010
    } funct_e;

    // The same instruction word seen as R-type and as I-type.
    typedef union packed {
        struct packed {
            logic [5:0] op;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r;
        struct packed {
            logic [5:0]  op;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i;
    } inst_u;

    typedef struct packed {
        logic        req;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wdata;
    } mem_op_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [3:0]  rf_wen;
        logic [4:0]  rf_wnum;
        logic [31:0] rf_wdata;
    } dbg_wb_t;

endpackage
